/* bench/test_input.txt */
# op, then address or count, then data or expected value; every number is hex
# drain: second column 0 = pattern words only, 1 = pattern and counter words taking turns
test    1    0
write   0000 a0
read    0000 a0
write   0010 11
write   0013 44
read    0010 11
read    0013 44
read    0012 00
read    0004 00
read    0040 00
write   0000 00
test    2    0
randpat 0    0
write   0000 02
wait    3    0
write   0000 00
drain   0    0
test    3    0
write   0030 00
write   0035 5a
write   003f 00
wait    4    0
read    0020 03
host    c    00
read    0020 00
test    4    0
write   0000 01
wait    1e   0
read    0020 10
write   0000 00
host    40   0c
read    0020 00
test    5    0
reset   0    0
randpat 0    0
write   0000 03
wait    1e   0
read    0020 10
write   0000 00
drain   1    00
test    6    0
write   0030 00
wait    4    0
read    0020 01
write   0000 04
host    8    00
read    0020 01
write   0000 00
host    4    20
write   0000 04
host    4    08
write   0000 00
read    0020 00

/* flist.f */
source/bus_pkg.sv
source/stream_pkg.sv
source/ctrl_if.sv
source/ctrl_regs.sv
source/source_arbiter.sv
source/word_fifo.sv
source/sram_test.sv
bench/sram_test_properties.sv
bench/tb_sram_test.sv

/* run.sh */
#!/bin/sh
# compiles the design and testbench with verilator, then runs the simulation from the project root.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module tb_sram_test -Mdir obj_dir
sim_out=$(./obj_dir/Vtb_sram_test 2>&1) || true
echo "$sim_out"
if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

/* bench/tb_sram_test.sv */
// testbench for sram_test; stimulus comes from bench/test_input.txt, so run it from the project root.
`timescale 1ns/1ps

module tb_sram_test;

    logic               BUS_CLK;
    logic               BUS_RST;
    bus_pkg::bus_addr_t bus_add;
    bus_pkg::bus_data_t bus_data_in;
    bus_pkg::bus_data_t bus_data_out;
    logic               bus_wr;
    logic               bus_rd;
    logic               usb_read;
    stream_pkg::byte_t  usb_data;
    logic               fifo_empty;

    string       op_q[$];
    logic [31:0] arg_q[$];
    logic [31:0] val_q[$];
    bit          stimulus_loaded;
    int          cmd_total;
    integer      seed = 32'h3f7e;
    logic [31:0] pattern_word; // last random pattern written.
    int          error_count;
    int          check_count;
    int          test_count;
    int          cur_test;
    int          test_checks;
    int          test_errors;

    sram_test uut (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .usb_read     (usb_read),
        .usb_data     (usb_data),
        .fifo_empty   (fifo_empty)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #2 BUS_CLK = ~BUS_CLK;
    end

    task automatic check_value(input string name, input stream_pkg::byte_t expected,
                               input stream_pkg::byte_t actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("Error at %0t ns: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        test_errors++;
        $display("test %0d failed: %s", cur_test, msg);
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            test_count++;
            $display("test %0d finished: %0d checks, %0d errors",
                     cur_test, test_checks, test_errors);
        end
        cur_test = 0;
    endtask

    task automatic load_stimulus(output bit ok);
        integer      fd;
        integer      fields;
        string       line;
        string       op_name;
        logic [31:0] arg;
        logic [31:0] val;
        fd = $fopen("bench/test_input.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    fields = $sscanf(line, "%s %h %h", op_name, arg, val);
                    if (fields == 3 && op_name != "#") begin // comment lines stop early.
                        op_q.push_back(op_name);
                        arg_q.push_back(arg);
                        val_q.push_back(val);
                    end
                end
            end
            $fclose(fd);
        end
        cmd_total = op_q.size();
        stimulus_loaded = 1'b1;
    endtask

    task automatic apply_reset();
        BUS_RST = 1'b1;
        repeat (16) @(posedge BUS_CLK);
        #1;
        BUS_RST = 1'b0;
    endtask

    task automatic bus_write(input bus_pkg::bus_addr_t addr, input bus_pkg::bus_data_t data);
        @(posedge BUS_CLK);
        #1;
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(posedge BUS_CLK);
        #1;
        bus_wr = 1'b0;
    endtask

    // read data is registered, so it is sampled one edge after bus_rd.
    task automatic bus_read_check(input bus_pkg::bus_addr_t addr,
                                  input bus_pkg::bus_data_t expected);
        @(posedge BUS_CLK);
        #1;
        bus_add = addr;
        bus_rd  = 1'b1;
        @(posedge BUS_CLK);
        #1;
        bus_rd = 1'b0;
        check_value("bus_data_out", expected, bus_data_out);
    endtask

    task automatic host_read_check(input logic [31:0] count, input stream_pkg::byte_t first);
        int                i;
        stream_pkg::byte_t expected;
        expected = first;
        for (i = 0; i < count; i++) begin
            @(posedge BUS_CLK);
            #1;
            check_value("usb_data", expected, usb_data);
            usb_read = 1'b1;
            expected = expected + 8'd1;
        end
        @(posedge BUS_CLK);
        #1;
        usb_read = 1'b0;
    endtask

    // kind 0 expects only pattern words, kind 1 pattern and counter words in turn.
    task automatic drain_check(input logic [31:0] kind, input stream_pkg::byte_t first);
        int                n;
        bit                done;
        stream_pkg::byte_t expected;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge BUS_CLK);
            #1;
            if (fifo_empty || n == 4 * stream_pkg::fifo_depth) begin
                usb_read = 1'b0;
                done = 1'b1;
            end else begin
                if (kind == 0 || (n / 4) % 2 == 0)
                    expected = pattern_word[8 * (n % 4) +: 8];
                else
                    expected = first + 8'(4 * (n / 8) + n % 4); // counter word n/8.
                check_value("usb_data", expected, usb_data);
                usb_read = 1'b1;
                n++;
            end
        end
        if (!fifo_empty)
            report_failure("the fifo still held words after a full drain");
        else if (n == 0 || n % 4 != 0)
            report_failure($sformatf("drain gave %0d bytes, not a whole number of words", n));
    endtask

    task automatic load_random_pattern();
        int i;
        pattern_word = $random(seed);
        for (i = 0; i < 4; i++)
            bus_write(bus_pkg::pattern_base + 16'(i), pattern_word[8 * i +: 8]);
    endtask

    task automatic run_commands();
        int          idx;
        logic [31:0] arg;
        logic [31:0] val;
        for (idx = 0; idx < cmd_total; idx++) begin
            arg = arg_q[idx];
            val = val_q[idx];
            case (op_q[idx])
                "test": begin
                    close_test();
                    cur_test    = arg;
                    test_checks = 0;
                    test_errors = 0;
                end
                "reset":   apply_reset();
                "write":   bus_write(arg[15:0], val[7:0]);
                "read":    bus_read_check(arg[15:0], val[7:0]);
                "host":    host_read_check(arg, val[7:0]);
                "drain":   drain_check(arg, val[7:0]);
                "randpat": load_random_pattern();
                "wait":    repeat (arg) @(posedge BUS_CLK);
                default:   report_failure($sformatf("unknown command %s", op_q[idx]));
            endcase
        end
    endtask

    initial begin : watchdog
        int limit;
        wait (stimulus_loaded);
        limit = cmd_total * 50 + 1000;
        repeat (limit) @(posedge BUS_CLK);
        $display("watchdog expired after %0d cycles before the stimulus completed", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        bit ok;
        BUS_RST     = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        usb_read    = 1'b0;
        cur_test    = 0;
        load_stimulus(ok);
        if (!ok) begin
            $display("stimulus file bench/test_input.txt could not be opened");
            $display("Simulation failed");
            $finish;
        end else begin
            apply_reset();
            run_commands();
            close_test();
            $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
            if (error_count == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

/* bench/sram_test_properties.sv */
// fifo and arbiter checks bound into word_fifo; the arbiter strobes are seen at the fifo ports.
`timescale 1ns/1ps

module sram_test_properties (
    input logic                    BUS_CLK,
    input logic                    BUS_RST,
    input logic                    word_wr,
    input logic                    fifo_full,
    input logic                    fifo_empty,
    input stream_pkg::fifo_count_t fifo_count,
    input logic                    trigger
);

    no_write_when_full: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        !(word_wr && fifo_full))
        else $error("word_wr high while the fifo is full");

    full_and_empty_exclusive: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        !(fifo_full && fifo_empty))
        else $error("fifo_full and fifo_empty high together");

    count_in_range: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        fifo_count <= stream_pkg::fifo_count_t'(stream_pkg::fifo_depth))
        else $error("fifo_count above the fifo depth");

    // back to back pulse writes are not expected.
    trigger_single_cycle: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        trigger |=> !trigger)
        else $error("trigger held for more than one cycle");

endmodule

bind word_fifo sram_test_properties props (
    .BUS_CLK    (BUS_CLK),
    .BUS_RST    (BUS_RST),
    .word_wr    (word_wr),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .fifo_count (fifo_count),
    .trigger    (ctrl.trigger)
);

/* source/sram_test.sv */
// top level of the exerciser; bus and host data use separate in and out ports.
`timescale 1ns/1ps

module sram_test (
    input  logic               BUS_CLK,
    input  logic               BUS_RST,
    input  bus_pkg::bus_addr_t bus_add,
    input  bus_pkg::bus_data_t bus_data_in,
    output bus_pkg::bus_data_t bus_data_out,
    input  logic               bus_wr,
    input  logic               bus_rd,
    input  logic               usb_read,
    output stream_pkg::byte_t  usb_data,
    output logic               fifo_empty
);

    logic                    word_wr;
    stream_pkg::word_t       word_data;
    logic                    fifo_full;
    stream_pkg::fifo_count_t fifo_count;

    ctrl_if ctrl_bus ();

    ctrl_regs i_ctrl_regs (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .fifo_count   (fifo_count),
        .ctrl         (ctrl_bus)
    );

    source_arbiter i_source_arbiter (
        .BUS_CLK   (BUS_CLK),
        .BUS_RST   (BUS_RST),
        .ctrl      (ctrl_bus),
        .fifo_full (fifo_full),
        .word_wr   (word_wr),
        .word_data (word_data)
    );

    word_fifo i_word_fifo (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .ctrl       (ctrl_bus),
        .word_wr    (word_wr),
        .word_data  (word_data),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .fifo_count (fifo_count),
        .usb_read   (usb_read),
        .usb_data   (usb_data)
    );

endmodule

/* source/word_fifo.sv */
// 16-word fifo read out one byte per usb_read, lowest byte first; direct mode bypasses it.
`timescale 1ns/1ps

module word_fifo (
    input  logic                    BUS_CLK,
    input  logic                    BUS_RST,
    ctrl_if.src                     ctrl,
    input  logic                    word_wr,
    input  stream_pkg::word_t       word_data,
    output logic                    fifo_full,
    output logic                    fifo_empty,
    output stream_pkg::fifo_count_t fifo_count,
    input  logic                    usb_read,
    output stream_pkg::byte_t       usb_data
);

    stream_pkg::word_t mem [stream_pkg::fifo_depth];

    logic [$clog2(stream_pkg::fifo_depth)-1:0] wr_ptr;
    logic [$clog2(stream_pkg::fifo_depth)-1:0] rd_ptr;

    logic [1:0]        byte_idx;
    stream_pkg::byte_t direct_cnt;
    stream_pkg::byte_t fifo_byte;
    logic              push;
    logic              byte_read;
    logic              pop;

    assign fifo_full  = (fifo_count == stream_pkg::fifo_count_t'(stream_pkg::fifo_depth));
    assign fifo_empty = (fifo_count == '0);

    assign push      = word_wr && !fifo_full;
    assign byte_read = usb_read && !ctrl.counter_direct && !fifo_empty;
    assign pop       = byte_read && (byte_idx == 2'd3); // last byte of the word.

    always_ff @(posedge BUS_CLK) begin
        if (push)
            mem[wr_ptr] <= word_data;
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST)
            fifo_count <= '0;
        else if (push && !pop)
            fifo_count <= fifo_count + 5'd1;
        else if (pop && !push)
            fifo_count <= fifo_count - 5'd1;
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST)
            byte_idx <= '0;
        else if (byte_read)
            byte_idx <= byte_idx + 2'd1;
    end

    // free running, advances only on direct reads.
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST)
            direct_cnt <= '0;
        else if (usb_read && ctrl.counter_direct)
            direct_cnt <= direct_cnt + 8'd1;
    end

    assign fifo_byte = mem[rd_ptr][8*byte_idx +: 8];

    always_comb begin
        if (ctrl.counter_direct)
            usb_data = direct_cnt;
        else if (fifo_empty)
            usb_data = '0;
        else
            usb_data = fifo_byte;
    end

endmodule

/* source/source_arbiter.sv */
// two-source round robin into the fifo; a trigger that meets a full fifo is dropped.
`timescale 1ns/1ps

module source_arbiter (
    input  logic              BUS_CLK,
    input  logic              BUS_RST,
    ctrl_if.src               ctrl,
    input  logic              fifo_full,
    output logic              word_wr,
    output stream_pkg::word_t word_data
);

    stream_pkg::arb_state_t prio;
    stream_pkg::word_t      word_count;
    stream_pkg::byte_t      cnt_byte;
    stream_pkg::word_t      counter_word;
    logic                   req_pattern;
    logic                   req_counter;
    logic                   grant_pattern;
    logic                   grant_counter;

    assign req_pattern = ctrl.pattern_en;
    assign req_counter = ctrl.counter_en || ctrl.trigger;

    // pattern wins on its turn or when the counter is idle.
    assign grant_pattern = !fifo_full && req_pattern &&
                           ((prio == stream_pkg::prio_pattern) || !req_counter);
    assign grant_counter = !fifo_full && req_counter && !grant_pattern;

    // counter word c carries bytes 4c to 4c+3, lowest first.
    assign cnt_byte     = stream_pkg::byte_t'(word_count << 2);
    assign counter_word = {cnt_byte + 8'd3, cnt_byte + 8'd2, cnt_byte + 8'd1, cnt_byte};

    assign word_wr   = grant_pattern || grant_counter;
    assign word_data = grant_pattern ? ctrl.pattern : counter_word;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST)
            prio <= stream_pkg::prio_pattern;
        else if (grant_pattern)
            prio <= stream_pkg::prio_counter;
        else if (grant_counter)
            prio <= stream_pkg::prio_pattern;
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST)
            word_count <= '0;
        else if (grant_counter)
            word_count <= word_count + 32'd1; // only on an accepted word.
    end

endmodule

/* source/ctrl_regs.sv */
// register block with a fixed address map; read data appears the cycle after bus_rd and holds.
`timescale 1ns/1ps

module ctrl_regs (
    input  logic                    BUS_CLK,
    input  logic                    BUS_RST,
    input  bus_pkg::bus_addr_t      bus_add,
    input  bus_pkg::bus_data_t      bus_data_in,
    output bus_pkg::bus_data_t      bus_data_out,
    input  logic                    bus_wr,
    input  logic                    bus_rd,
    input  stream_pkg::fifo_count_t fifo_count,
    ctrl_if.regs                    ctrl
);

    bus_pkg::bus_addr_t win_base;
    bus_pkg::bus_addr_t offset;
    logic               sel_ctrl;
    logic               sel_pattern;
    logic               sel_fifo;
    logic               sel_pulse;
    logic               ctrl_hit;
    logic               pattern_hit;
    logic               fifo_hit;
    bus_pkg::bus_data_t ctrl_reg;
    stream_pkg::word_t  pattern_reg;
    logic               trigger_q;
    bus_pkg::bus_data_t rd_data;

    // window decode.
    assign win_base    = bus_add & ~bus_pkg::window_mask;
    assign offset      = bus_add & bus_pkg::window_mask;
    assign sel_ctrl    = (win_base == bus_pkg::ctrl_base);
    assign sel_pattern = (win_base == bus_pkg::pattern_base);
    assign sel_fifo    = (win_base == bus_pkg::fifo_base);
    assign sel_pulse   = (win_base == bus_pkg::pulse_base);

    assign ctrl_hit    = sel_ctrl && (offset == '0);
    assign pattern_hit = sel_pattern && (offset < 16'd4);
    assign fifo_hit    = sel_fifo && (offset == '0);

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            ctrl_reg    <= '0;
            pattern_reg <= '0;
        end else if (bus_wr) begin
            if (ctrl_hit)
                ctrl_reg <= bus_data_in;
            if (pattern_hit)
                pattern_reg[8*offset[1:0] +: 8] <= bus_data_in; // little endian bytes.
        end
    end

    // one pulse per write into the pulse window, data ignored.
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST)
            trigger_q <= 1'b0;
        else
            trigger_q <= bus_wr && sel_pulse;
    end

    // bit 0 counter enable, bit 1 pattern enable, bit 2 direct mode.
    assign ctrl.counter_en     = ctrl_reg[0];
    assign ctrl.pattern_en     = ctrl_reg[1];
    assign ctrl.counter_direct = ctrl_reg[2];
    assign ctrl.pattern        = pattern_reg;
    assign ctrl.trigger        = trigger_q;

    always_comb begin
        rd_data = '0; // unmapped reads as zero.
        if (ctrl_hit)
            rd_data = ctrl_reg;
        else if (pattern_hit)
            rd_data = pattern_reg[8*offset[1:0] +: 8];
        else if (fifo_hit)
            rd_data = bus_pkg::bus_data_t'(fifo_count);
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST)
            bus_data_out <= '0;
        else if (bus_rd)
            bus_data_out <= rd_data;
    end

endmodule

/* source/ctrl_if.sv */
// control levels, pattern word and a one-cycle trigger; driven only by the register block.
`timescale 1ns/1ps

interface ctrl_if;
    logic              counter_en;
    logic              pattern_en;
    logic              counter_direct;
    stream_pkg::word_t pattern;
    logic              trigger; // single cycle.

    modport regs (
        output counter_en, pattern_en, counter_direct, pattern, trigger
    );

    modport src (
        input counter_en, pattern_en, counter_direct, pattern, trigger
    );

endinterface

/* source/stream_pkg.sv */
// stream word and byte types; the fifo holds at most 16 words, so the count needs five bits.
package stream_pkg;

    typedef logic [31:0] word_t; // one fifo entry.
    typedef logic [7:0]  byte_t; // one host byte.

    localparam int fifo_depth = 16;

    // occupancy from 0 up to and including fifo_depth.
    typedef logic [4:0] fifo_count_t;

    // which source wins when both request.
    typedef enum logic {
        prio_pattern,
        prio_counter
    } arb_state_t;

endpackage

/* source/bus_pkg.sv */
// register bus types and the fixed address map; every window spans 16 addresses.
package bus_pkg;

    // byte-wide register bus.
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // window bases.
    localparam bus_addr_t ctrl_base    = 16'h0000; // control byte at offset 0.
    localparam bus_addr_t pattern_base = 16'h0010; // pattern bytes at offsets 0 to 3.
    localparam bus_addr_t fifo_base    = 16'h0020; // fifo occupancy at offset 0.
    localparam bus_addr_t pulse_base   = 16'h0030; // any write fires the trigger.

    // offset bits inside one window.
    localparam bus_addr_t window_mask  = 16'h000f;

endpackage
